//--- axist_lane_framer.sv
`timescale 1ns/1ns

`include "axist_link_config.svh"

module axist_lane_framer
(
   input  logic                       m_wr_clk,
   input  logic                       m_wr_rst_n,
   input  axist_link_pkg::user_beat_t i_rdata,      // FIFO head
   input  logic                       i_empty,
   input  logic [6:0]                 i_sl_tx_transfer_en,   // Follower side enables
   input  logic [6:0]                 i_ms_tx_transfer_en,   // Leader side enables
   output logic                       o_rd,
   output axist_link_pkg::lane_bus_t  o_lane_data
);

   import axist_link_pkg::*;

   localparam int STB_W = $clog2(`AXIST_STB_INTV);

   logic              tx_online;             // Every lane up on both ends
   logic [STB_W-1:0]  wd_cnt;                // Transmitted words mod interval
   logic              stb_now;
   lane_bus_t         lane_nxt;              // Framed beat ahead of the register

   // ------------------------------------------------------------------------
   // Pop control
   // ------------------------------------------------------------------------

   assign tx_online = &{i_sl_tx_transfer_en, i_ms_tx_transfer_en};
   assign o_rd      = tx_online && !i_empty;   // One beat per online cycle

   assign stb_now   = (wd_cnt == '0);

   // ------------------------------------------------------------------------
   // Slice beat across channels
   // ------------------------------------------------------------------------

   always_comb
   begin
      for (int k = 0; k < `AXIST_NUM_CH; k++)
      begin
         lane_nxt[k].spare  = '0;
         lane_nxt[k].data   = i_rdata[k*`AXIST_CH_DATA_W +: `AXIST_CH_DATA_W];   // Slice k
         lane_nxt[k].strobe = stb_now;      // Same strobe on all lanes
         lane_nxt[k].push   = 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // Output register and word counter
   // ------------------------------------------------------------------------

   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         o_lane_data <= '0;
         wd_cnt      <= '0;                  // First word carries strobe
      end
      else if (o_rd)
      begin
         o_lane_data <= lane_nxt;
         if (wd_cnt == STB_W'(`AXIST_STB_INTV - 1))
         begin
            wd_cnt <= '0;
         end
         else
         begin
            wd_cnt <= wd_cnt + 1'b1;
         end
      end
      else
      begin
         o_lane_data <= '0;                  // Idle word leaves the count alone
      end
   end

endmodule

//--- axist_link_config.svh
`ifndef AXIST_LINK_CONFIG_SVH
`define AXIST_LINK_CONFIG_SVH

// ---------------------------------------------------------------------------
// User side
// ---------------------------------------------------------------------------

`define AXIST_DATA_W       256   // User beat width
`define AXIST_INIT_CREDIT  8     // Remote slots free after reset
`define AXIST_FIFO_AW      2     // Staging FIFO, depth 4

// ---------------------------------------------------------------------------
// PHY side
// ---------------------------------------------------------------------------

`define AXIST_NUM_CH       8     // Channels carrying one beat
`define AXIST_CH_W         40    // Full channel word
`define AXIST_CH_DATA_W    32    // Payload slice per channel

// Strobe repeats on every 8th transmitted word, counted from word 0
`define AXIST_STB_INTV     8

`endif

//--- axist_link_input.txt
// One 256-bit user beat per line in hex, low 32 bits go to channel 0
0f1e2d3c4b5a69788796a5b4c3d2e1f000112233445566778899aabbccddeeff
deadbeefcafef00d0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a
1357924668ace0bdf0e1d2c3b4a5968778695a4b3c2d1e0f9182736455463728
ffffffff00000000aaaaaaaa5555555512345678876543219abcdef0fedcba09
3ca5e1f0b7d2049c6e81a3f527c04db98f16e2a05d3b79c4a1e8062fc4970b3d
0000000100000002000000030000000400000005000000060000000700000008
8000000040000000200000001000000008000000040000000200000001000000
c0ffee00b16b00b5facefeed0badf00d1badcafe8badf00dbaadf00dfeedface
7f3a91c2e4580db61ca79f0348be26d5f1c03a7e95b2d64e0817c3fa2e6b9d54
a1b2c3d4e5f60718293a4b5c6d7e8f90102132435465768798a9bacbdcedfe0f
5e5e5e5e4d4d4d4d3c3c3c3c2b2b2b2b1a1a1a1a0909090978787878e7e7e7e7
96c4f2a83b1d5e7009e8c6a4f3b1d97525476a8cbde0f1239c8a7b6e5d4c3b2a
00ff00ff11ee11ee22dd22dd33cc33cc44bb44bb55aa55aa6699669977887788
e2d9c8f71a6b4c3e5f0e9d8c7b6a5948372615041f2e3d4c5b6a79889aabbccd
4a3b2c1d0e9f8a7b6c5d4e3f20113243f0e0d0c0b0a0908070605040302010ff
bb8e73a2c61f05d94e27b08c3af591e6d2047cb968e13fa51c7b2d0e846f39a0
0123012301230123456745674567456789ab89ab89ab89abcdefcdefcdefcdef
f7e6d5c4b3a29180706f5e4d3c2b1a0998877665544332211009f8e7d6c5b4a3
2468ace013579bdf2468ace113579bde2468ace213579bdd2468ace313579bdc
9d0c8b7a6f5e4d3c2b1a09f8e7d6c5b4a39281706f5e4d3c2b1a0987f6e5d4c3
55aa33cc0ff0c33c996669969a5965a6a55a5aa5c3c33c3cf00f0ff0aa5555aa
6b5e4a3f2817d0c9b8a796857463524130201f0e9dac8b7a6f5e4d3c2b1a0908
e81c5b2f7a9d046e3c8b1f5a29d7e0c64b8a3f61d2e59c07a4f18b3e6c2d5907
fedcba9801234567fedcba9801234567a0b1c2d3e4f5061728394a5b6c7d8e9f

//--- axist_link_pkg.sv
`include "axist_link_config.svh"

package axist_link_pkg;

   // One beat as seen on the user AXI-ST port
   typedef logic [`AXIST_DATA_W-1:0] user_beat_t;

   // ------------------------------------------------------------------------
   // Channel word layout, push in bit 0
   // ------------------------------------------------------------------------

   typedef struct packed
   {
      logic [`AXIST_CH_W-`AXIST_CH_DATA_W-3:0] spare;   // Bits 39:34, tied low
      logic [`AXIST_CH_DATA_W-1:0]             data;    // Bits 33:2
      logic                                    strobe;  // Bit 1
      logic                                    push;    // Bit 0, valid word
   } ch_word_t;

   // All channels side by side, channel 0 in the low bits
   typedef ch_word_t [`AXIST_NUM_CH-1:0] lane_bus_t;

   // Sized to hold the full initial credit
   typedef logic [$clog2(`AXIST_INIT_CREDIT+1)-1:0] credit_t;

endpackage

//--- axist_link_top.f
+incdir+.
axist_link_pkg.sv
axist_tx_credit_gate.sv
axist_tx_fifo.sv
axist_lane_framer.sv
axist_link_top.sv
tb_axist_link_top.sv

//--- axist_link_top.sv
`timescale 1ns/1ns

module axist_link_top
(
   input  logic                       m_wr_clk,
   input  logic                       m_wr_rst_n,
   input  axist_link_pkg::user_beat_t i_user_tdata,
   input  logic                       i_user_tvalid,
   input  logic                       i_credit_return,
   input  logic [6:0]                 i_sl_tx_transfer_en,
   input  logic [6:0]                 i_ms_tx_transfer_en,
   output logic                       o_user_tready,
   output axist_link_pkg::lane_bus_t  o_lane_data
);

   import axist_link_pkg::*;

   user_beat_t  fifo_wdata;                  // Gate to FIFO
   logic        fifo_wr;
   logic        fifo_full;
   user_beat_t  fifo_rdata;                  // FIFO to framer
   logic        fifo_rd;
   logic        fifo_empty;

   // ------------------------------------------------------------------------
   // Producer, buffer, consumer
   // ------------------------------------------------------------------------

   axist_tx_credit_gate u_credit_gate
   (
      .m_wr_clk        (m_wr_clk),
      .m_wr_rst_n      (m_wr_rst_n),
      .i_user_tdata    (i_user_tdata),
      .i_user_tvalid   (i_user_tvalid),
      .i_credit_return (i_credit_return),
      .i_fifo_full     (fifo_full),
      .o_user_tready   (o_user_tready),
      .o_fifo_wdata    (fifo_wdata),
      .o_fifo_wr       (fifo_wr)
   );

   axist_tx_fifo u_tx_fifo
   (
      .m_wr_clk   (m_wr_clk),
      .m_wr_rst_n (m_wr_rst_n),
      .i_wdata    (fifo_wdata),
      .i_wr       (fifo_wr),
      .i_rd       (fifo_rd),
      .o_rdata    (fifo_rdata),
      .o_full     (fifo_full),
      .o_empty    (fifo_empty)
   );

   axist_lane_framer u_lane_framer
   (
      .m_wr_clk            (m_wr_clk),
      .m_wr_rst_n          (m_wr_rst_n),
      .i_rdata             (fifo_rdata),
      .i_empty             (fifo_empty),
      .i_sl_tx_transfer_en (i_sl_tx_transfer_en),
      .i_ms_tx_transfer_en (i_ms_tx_transfer_en),
      .o_rd                (fifo_rd),
      .o_lane_data         (o_lane_data)
   );

endmodule

//--- axist_tx_credit_gate.sv
`timescale 1ns/1ns

`include "axist_link_config.svh"

module axist_tx_credit_gate
(
   input  logic                       m_wr_clk,
   input  logic                       m_wr_rst_n,
   input  axist_link_pkg::user_beat_t i_user_tdata,
   input  logic                       i_user_tvalid,
   input  logic                       i_credit_return,   // One freed remote slot
   input  logic                       i_fifo_full,
   output logic                       o_user_tready,
   output axist_link_pkg::user_beat_t o_fifo_wdata,
   output logic                       o_fifo_wr
);

   import axist_link_pkg::*;

   credit_t credit_cnt;                      // Remote slots still free
   logic    accept;                          // Beat taken this cycle

   // ------------------------------------------------------------------------
   // Handshake
   // ------------------------------------------------------------------------

   assign o_user_tready = (credit_cnt != '0) && !i_fifo_full;   // Need a slot both ends
   assign accept        = i_user_tvalid && o_user_tready;

   assign o_fifo_wr     = accept;            // Write on the accepting edge
   assign o_fifo_wdata  = i_user_tdata;

   // ------------------------------------------------------------------------
   // Credit counter
   // ------------------------------------------------------------------------

   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         credit_cnt <= credit_t'(`AXIST_INIT_CREDIT);  // Remote buffer empty
      end
      else
      begin
         case ({accept, i_credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;   // Spend only
            2'b01:   credit_cnt <= credit_cnt + 1'b1;   // Return only
            default: credit_cnt <= credit_cnt;          // Both or neither
         endcase
      end
   end

   // Remote side must never hand back more slots than it was given
   a_credit_bound : assert property (
      @(posedge m_wr_clk) disable iff (!m_wr_rst_n)
      credit_cnt <= credit_t'(`AXIST_INIT_CREDIT)
   );

endmodule

//--- axist_tx_fifo.sv
`timescale 1ns/1ns

`include "axist_link_config.svh"

module axist_tx_fifo
(
   input  logic                       m_wr_clk,
   input  logic                       m_wr_rst_n,
   input  axist_link_pkg::user_beat_t i_wdata,
   input  logic                       i_wr,
   input  logic                       i_rd,
   output axist_link_pkg::user_beat_t o_rdata,      // Head entry, fall-through
   output logic                       o_full,
   output logic                       o_empty
);

   import axist_link_pkg::*;

   localparam int AW    = `AXIST_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   user_beat_t    mem [DEPTH];               // Beat storage
   logic [AW:0]   wr_ptr;                    // MSB is the wrap bit
   logic [AW:0]   rd_ptr;
   logic          do_wr;
   logic          do_rd;

   assign do_wr = i_wr && !o_full;
   assign do_rd = i_rd && !o_empty;

   // ------------------------------------------------------------------------
   // Flags from pointer compare
   // ------------------------------------------------------------------------

   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);   // Same slot, one lap apart

   assign o_rdata = mem[rd_ptr[AW-1:0]];    // Readable right after the write edge

   // ------------------------------------------------------------------------
   // Storage and pointers
   // ------------------------------------------------------------------------

   always_ff @(posedge m_wr_clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr[AW-1:0]] <= i_wdata;
      end
   end

   always_ff @(posedge m_wr_clk)
   begin
      if (!m_wr_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Framer side must hold off until an entry has landed
   a_no_rd_empty : assert property (
      @(posedge m_wr_clk) disable iff (!m_wr_rst_n)
      i_rd |-> !o_empty
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI-ST link testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --timescale 1ns/1ns \
   --top-module tb_axist_link_top \
   -f axist_link_top.f \
   -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failures"

//--- tb_axist_link_top.sv
`timescale 1ns/1ns

`include "axist_link_config.svh"

module tb_axist_link_top;

   localparam int N_BEATS     = 24;
   localparam int RST_CYC     = 10;
   localparam int HOLD_CYC    = 40;          // No credit returns before this cycle
   localparam int EN_OFF_FROM = 60;          // Lane bit 3 of the follower enables low
   localparam int EN_OFF_TO   = 100;
   localparam int TIMEOUT_CYC = N_BEATS * 40 + RST_CYC;

   logic           m_wr_clk;
   logic           m_wr_rst_n;
   logic [255:0]   user_tdata;
   logic           user_tvalid;
   logic           credit_return;
   logic [6:0]     sl_en;
   logic [6:0]     ms_en;
   logic           user_tready;
   logic [319:0]   lane_data;                // Channel 0 in the low 40 bits

   logic [255:0]   beats [N_BEATS];          // Stimulus and expected payload
   logic [255:0]   exp_q [$];                // Accepted but not yet on the lanes
   logic [31:0]    lfsr;
   logic           vld;                      // Beat on offer held until taken
   int             model_credit;
   int             word_cnt;                 // Pushed words seen so far
   int             beat_idx;                 // Next beat to offer
   int             rx_cnt;
   int             cyc;                      // Cycles since reset release
   int             clk_cnt;
   int             mism_cnt;
   int             fail_cnt;

   axist_link_top dut
   (
      .m_wr_clk            (m_wr_clk),
      .m_wr_rst_n          (m_wr_rst_n),
      .i_user_tdata        (user_tdata),
      .i_user_tvalid       (user_tvalid),
      .i_credit_return     (credit_return),
      .i_sl_tx_transfer_en (sl_en),
      .i_ms_tx_transfer_en (ms_en),
      .o_user_tready       (user_tready),
      .o_lane_data         (lane_data)
   );

   initial
   begin
      m_wr_clk = 1'b0;
      forever #5 m_wr_clk = ~m_wr_clk;      // 10 ns period
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];
   endtask

   task automatic check_eq(input string name, input logic [319:0] exp, input logic [319:0] act);
      if (act !== exp)
      begin
         mism_cnt++;
         $display("mismatch %s at %0t: expected %0h actual %0h", name, $time, exp, act);
      end
   endtask

   // ------------------------------------------------------------------------
   // Output side sees the word registered at the last rising edge
   // ------------------------------------------------------------------------

   task automatic check_lane();
      logic [255:0] beat;
      logic [39:0]  exp_word;
      logic         stb;
      if (lane_data[0])                      // Push on channel 0
      begin
         if (!(&{sl_en, ms_en}))
         begin
            fail_cnt++;
            $display("a pushed word went out while a transfer enable bit was low");
         end
         if (exp_q.size() == 0)
         begin
            fail_cnt++;
            $display("a pushed word went out with no accepted beat waiting for it");
         end
         else
         begin
            beat = exp_q.pop_front();
            stb  = (word_cnt % `AXIST_STB_INTV) == 0;
            for (int k = 0; k < `AXIST_NUM_CH; k++)
            begin
               exp_word = {6'b0, beat[k*`AXIST_CH_DATA_W +: `AXIST_CH_DATA_W], stb, 1'b1};
               check_eq($sformatf("beat%0d_ch%0d", rx_cnt, k), exp_word,
                        lane_data[k*`AXIST_CH_W +: `AXIST_CH_W]);
            end
            word_cnt++;
            rx_cnt++;
         end
      end
      else
      begin
         check_eq("idle_word", '0, lane_data);   // Strobe included and the count holds
      end
   endtask

   task automatic check_tready();
      if (cyc == 1)
      begin
         check_eq("tready_after_reset", 1, user_tready);
      end
      if (model_credit == 0)
      begin
         check_eq("tready_no_credit", 0, user_tready);
      end
   endtask

   // ------------------------------------------------------------------------
   // Input side takes effect at the next rising edge
   // ------------------------------------------------------------------------

   task automatic drive_cycle();
      logic pick;
      logic acc;
      logic ret;
      if (cyc == HOLD_CYC)
      begin
         check_eq("accepts_without_returns", `AXIST_INIT_CREDIT, beat_idx);
      end
      if (!vld && beat_idx < N_BEATS)
      begin
         draw_bit(pick);                     // Random valid gap
         vld = pick;
      end
      user_tvalid = vld;
      user_tdata  = (beat_idx < N_BEATS) ? beats[beat_idx] : '0;
      acc         = vld && user_tready;      // Ready only moves on the rising edge
      if (acc)
      begin
         exp_q.push_back(beats[beat_idx]);
         beat_idx++;
         vld = 1'b0;
      end
      ret = 1'b0;
      if (cyc > HOLD_CYC)
      begin
         draw_bit(pick);
         ret = pick && (model_credit - int'(acc) < `AXIST_INIT_CREDIT);   // Never over-return
      end
      credit_return = ret;
      model_credit  = model_credit - int'(acc) + int'(ret);
      sl_en         = (cyc >= EN_OFF_FROM && cyc < EN_OFF_TO) ? 7'h77 : 7'h7f;
   endtask

   initial
   begin
      clk_cnt = 0;
      while (clk_cnt < TIMEOUT_CYC)
      begin
         @(posedge m_wr_clk);
         clk_cnt++;
      end
      $display("timeout after %0d cycles with %0d of %0d beats delivered",
               clk_cnt, rx_cnt, N_BEATS);
      $display("test failed");
      $finish;
   end

   initial
   begin
      m_wr_rst_n    = 1'b0;
      user_tdata    = '0;
      user_tvalid   = 1'b0;
      credit_return = 1'b0;
      sl_en         = 7'h7f;
      ms_en         = 7'h7f;
      lfsr          = 32'h367219bd;
      vld           = 1'b0;
      model_credit  = `AXIST_INIT_CREDIT;
      word_cnt      = 0;
      beat_idx      = 0;
      rx_cnt        = 0;
      cyc           = 0;
      mism_cnt      = 0;
      fail_cnt      = 0;
      $readmemh("axist_link_input.txt", beats);
      if ($isunknown(beats[N_BEATS-1]))
      begin
         fail_cnt++;
         $display("the input file did not supply all %0d beats", N_BEATS);
      end

      for (int i = 0; i < RST_CYC; i++)
      begin
         @(negedge m_wr_clk);
         check_eq("reset_lane", '0, lane_data);
         check_eq("reset_tready", 1, user_tready);
      end
      m_wr_rst_n = 1'b1;

      while (rx_cnt < N_BEATS)
      begin
         @(negedge m_wr_clk);
         cyc++;
         check_lane();
         check_tready();
         drive_cycle();
      end

      // Trailing cycles catch any word beyond the last beat
      for (int i = 0; i < (1 << `AXIST_FIFO_AW); i++)
      begin
         @(negedge m_wr_clk);
         cyc++;
         check_lane();
         check_tready();
         drive_cycle();
      end

      $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
      if (mism_cnt == 0 && fail_cnt == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule
